// File: design/lsp_az_defines.svh
`ifndef LSP_AZ_DEFINES_SVH
`define LSP_AZ_DEFINES_SVH

// LPC order, ten LSPs per frame and eleven coefficients out
`define LSP_AZ_ORDER 10

// Order of each of the two LSP polynomials
`define LSP_AZ_HALF 5

// LSP cosines in Q15, coefficients in Q12
`define LSP_AZ_LSP_W 16

// Polynomial words in Q24
`define LSP_AZ_POL_W 32

// Q24 to Q12 with one extra halving from the f1/f2 fold
`define LSP_AZ_SHIFT 13

`endif

// File: design/lsp_az_pkg.sv
`include "lsp_az_defines.svh"

package lsp_az_pkg;

	typedef logic signed [`LSP_AZ_LSP_W-1:0] lsp_word_t;
	typedef logic signed [`LSP_AZ_POL_W-1:0] pol_word_t;

	// Pair k carries LSP 2k in the low half and LSP 2k+1 in the high half
	typedef struct packed {
		lsp_word_t odd;
		lsp_word_t even;
	} lsp_pair_t;

	typedef union packed {
		lsp_word_t [`LSP_AZ_ORDER-1:0] lsp;
		lsp_pair_t [`LSP_AZ_HALF-1:0]  pair;
	} lsp_frame_u;

	typedef lsp_word_t [`LSP_AZ_HALF-1:0] lsp_half_t;
	typedef pol_word_t [`LSP_AZ_HALF:0]   pol_array_t;
	typedef lsp_word_t [`LSP_AZ_ORDER:0]  az_frame_t;

	localparam pol_word_t POL_MAX = {1'b0, {(`LSP_AZ_POL_W-1){1'b1}}};
	localparam pol_word_t POL_MIN = {1'b1, {(`LSP_AZ_POL_W-1){1'b0}}};

	// Clamp a one-bit-wide sum back to 32 bits, as L_add and L_sub do
	function automatic pol_word_t sat_pol(input logic signed [`LSP_AZ_POL_W:0] s);
		if (s[`LSP_AZ_POL_W] == s[`LSP_AZ_POL_W-1])
			return s[`LSP_AZ_POL_W-1:0];
		else if (s[`LSP_AZ_POL_W])
			return POL_MIN;
		else
			return POL_MAX;
	endfunction

	function automatic pol_word_t sat_add(input pol_word_t a, input pol_word_t b);
		logic signed [`LSP_AZ_POL_W:0] s;
		s = a + b;
		return sat_pol(s);
	endfunction

	function automatic pol_word_t sat_sub(input pol_word_t a, input pol_word_t b);
		logic signed [`LSP_AZ_POL_W:0] s;
		s = a - b;
		return sat_pol(s);
	endfunction

endpackage

// File: design/lsp_frame_decoder.sv
`timescale 1ns/1ns
`include "lsp_az_defines.svh"

module lsp_frame_decoder (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   in_req,
	input  lsp_az_pkg::lsp_frame_u in_frame,
	output logic                   in_ack,
	output logic                   pol_start,
	output lsp_az_pkg::lsp_half_t  even_lsp,
	output lsp_az_pkg::lsp_half_t  odd_lsp,
	input  logic                   f1_done,
	input  logic                   f2_done,
	input  logic                   comb_idle,
	output logic                   comb_go
);
	import lsp_az_pkg::*;

	lsp_frame_u hold;
	lsp_frame_u src;
	lsp_half_t  even_next;
	lsp_half_t  odd_next;
	logic       have_frame;
	logic       building;
	logic       f1_seen;
	logic       f2_seen;
	logic       take;
	logic       can_start;
	logic       launch;

	// New frame accepted only when the holding slot is empty
	assign take      = in_req && !in_ack && !have_frame;
	assign can_start = !building && comb_idle;
	assign launch    = can_start && (have_frame || take);

	// Straight from the port when the builders are free, else from the slot
	assign src = have_frame ? hold : in_frame;

	always_comb begin
		for (int k = 0; k < `LSP_AZ_HALF; k++) begin
			even_next[k] = src.pair[k].even;
			odd_next[k]  = src.pair[k].odd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake and builder sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			in_ack     <= 1'b0;
			have_frame <= 1'b0;
			building   <= 1'b0;
			pol_start  <= 1'b0;
			comb_go    <= 1'b0;
			f1_seen    <= 1'b0;
			f2_seen    <= 1'b0;
		end else begin
			pol_start <= launch;
			comb_go   <= 1'b0;

			if (take)
				in_ack <= 1'b1;
			else if (in_ack && !in_req)
				in_ack <= 1'b0;

			if (launch) begin
				have_frame <= 1'b0;
				building   <= 1'b1;
			end else if (take) begin
				have_frame <= 1'b1;
			end

			if (f1_done)
				f1_seen <= 1'b1;
			if (f2_done)
				f2_seen <= 1'b1;

			// Both polynomials ready, hand them to the combiner
			if (building && f1_seen && f2_seen && comb_idle) begin
				comb_go  <= 1'b1;
				building <= 1'b0;
				f1_seen  <= 1'b0;
				f2_seen  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take)
			hold <= in_frame;
		if (launch) begin
			even_lsp <= even_next;
			odd_lsp  <= odd_next;
		end
	end

endmodule

// File: design/lsp_pol_builder.sv
`timescale 1ns/1ns
`include "lsp_az_defines.svh"

module lsp_pol_builder (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  lsp_az_pkg::lsp_half_t  lsp,
	output logic                   done,
	output lsp_az_pkg::pol_array_t pol
);
	import lsp_az_pkg::*;

	// 1.0 in Q24
	localparam pol_word_t ONE_Q24 = 1 << 24;
	localparam lsp_word_t LSP_MIN = {1'b1, {(`LSP_AZ_LSP_W-1){1'b0}}};

	logic       busy;
	logic       first;
	logic [1:0] phase;
	logic [2:0] i;
	logic [2:0] k;
	logic       msu_step;
	lsp_word_t  n;
	lsp_word_t  hi;
	lsp_word_t  lo;
	pol_word_t  x;
	pol_word_t  base;
	pol_word_t  p_hi;
	pol_word_t  p_lo;
	pol_word_t  t0;

	function automatic pol_word_t shl1_sat(input pol_word_t v);
		if (v[`LSP_AZ_POL_W-1] != v[`LSP_AZ_POL_W-2])
			return v[`LSP_AZ_POL_W-1] ? POL_MIN : POL_MAX;
		return v <<< 1;
	endfunction

	// Init step and the closing f[1] update both subtract lsp*1024
	assign msu_step = first || (k == 3'd1);
	assign n        = first ? lsp[0] : lsp[i-1];

	// L_Extract of f[k-1]
	assign x  = pol[k-1];
	assign hi = x[`LSP_AZ_POL_W-1:16];
	assign lo = {1'b0, x[15:1]};

	// First update of f[i] starts from the copy of f[i-2]
	assign base = (k == i) ? pol[i-2] : pol[k];

	//////////////////////////////////////////////////////////////////////
	// Step sequencer, three cycles per step
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			first <= 1'b0;
			phase <= 2'd0;
			i     <= 3'd2;
			k     <= 3'd2;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				first <= 1'b1;
				phase <= 2'd0;
				i     <= 3'd2;
				k     <= 3'd2;
			end else if (busy) begin
				if (phase != 2'd2) begin
					phase <= phase + 2'd1;
				end else begin
					phase <= 2'd0;
					if (first) begin
						first <= 1'b0;
					end else if (k != 3'd1) begin
						k <= k - 3'd1;
					end else if (i == 3'(`LSP_AZ_HALF)) begin
						busy <= 1'b0;
						done <= 1'b1;
					end else begin
						i <= i + 3'd1;
						k <= i + 3'd1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath: products, then Mpy_32_16 sum, then write back
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (busy) begin
			case (phase)
				2'd0: begin
					// L_mult saturates only on -1 * -1
					if (hi == LSP_MIN && n == LSP_MIN)
						p_hi <= POL_MAX;
					else
						p_hi <= (pol_word_t'(hi) * pol_word_t'(n)) <<< 1;
					p_lo <= (pol_word_t'(lo) * pol_word_t'(n)) >>> 15;
				end
				2'd1: begin
					if (msu_step)
						t0 <= pol_word_t'(n) <<< 10;
					else
						t0 <= shl1_sat(sat_add(p_hi, p_lo <<< 1));
				end
				default: begin
					if (first) begin
						pol[0] <= ONE_Q24;
						pol[1] <= sat_sub('0, t0);
						for (int j = 2; j <= `LSP_AZ_HALF; j++)
							pol[j] <= '0;
					end else if (k == 3'd1) begin
						pol[1] <= sat_sub(pol[1], t0);
					end else begin
						pol[k] <= sat_sub(sat_add(base, pol[k-2]), t0);
					end
				end
			endcase
		end
	end

endmodule

// File: design/az_combiner.sv
`timescale 1ns/1ns
`include "lsp_az_defines.svh"

module az_combiner (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   go,
	input  lsp_az_pkg::pol_array_t f1,
	input  lsp_az_pkg::pol_array_t f2,
	output logic                   idle,
	input  logic                   port_busy,
	output logic                   load,
	output lsp_az_pkg::az_frame_t  az
);
	import lsp_az_pkg::*;

	// a[0] is 1.0 in Q12
	localparam lsp_word_t A0_Q12 = 1 << 12;

	typedef enum logic [1:0] {
		IDLE,
		FOLD,
		HOLD
	} state_t;

	state_t     state;
	logic [2:0] i;
	pol_array_t g1;
	pol_array_t g2;
	pol_word_t  s1;
	pol_word_t  s2;
	pol_word_t  sum;
	pol_word_t  diff;

	// L_shr_r by 13, then keep the low word
	function automatic lsp_word_t round_q12(input pol_word_t v);
		pol_word_t r;
		r = v >>> `LSP_AZ_SHIFT;
		if (v[`LSP_AZ_SHIFT-1])
			r = r + 1;
		return r[`LSP_AZ_LSP_W-1:0];
	endfunction

	// Going downward, g[i-1] is still the unfolded value
	assign s1   = sat_add(g1[i], g1[i-1]);
	assign s2   = sat_sub(g2[i], g2[i-1]);
	assign sum  = sat_add(s1, s2);
	assign diff = sat_sub(s1, s2);

	assign idle = (state == IDLE);

	//////////////////////////////////////////////////////////////////////
	// One coefficient pair per cycle, then wait for the result port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			i     <= 3'(`LSP_AZ_HALF);
			load  <= 1'b0;
		end else begin
			load <= 1'b0;
			case (state)
				IDLE: begin
					if (go) begin
						state <= FOLD;
						i     <= 3'(`LSP_AZ_HALF);
					end
				end
				FOLD: begin
					if (i != 3'd1) begin
						i <= i - 3'd1;
					end else if (!port_busy) begin
						load  <= 1'b1;
						state <= IDLE;
					end else begin
						state <= HOLD;
					end
				end
				default: begin
					if (!port_busy) begin
						load  <= 1'b1;
						state <= IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && go) begin
			g1    <= f1;
			g2    <= f2;
			az[0] <= A0_Q12;
		end
		if (state == FOLD) begin
			az[i]                     <= round_q12(sum);
			az[`LSP_AZ_ORDER + 1 - i] <= round_q12(diff);
		end
	end

endmodule

// File: design/az_result_port.sv
`timescale 1ns/1ns

module az_result_port (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  load,
	input  lsp_az_pkg::az_frame_t az,
	output logic                  busy,
	output logic                  out_req,
	output lsp_az_pkg::az_frame_t out_frame,
	input  logic                  out_ack
);

	//////////////////////////////////////////////////////////////////////
	// Output four-phase handshake
	//////////////////////////////////////////////////////////////////////

	// busy covers the whole handshake, out_req only its first half
	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			out_req <= 1'b0;
		end else if (!busy) begin
			if (load) begin
				busy    <= 1'b1;
				out_req <= 1'b1;
			end
		end else if (out_req) begin
			if (out_ack)
				out_req <= 1'b0;
		end else if (!out_ack) begin
			// Sink has released ack, slot free again
			busy <= 1'b0;
		end
	end

	// Frame stays put from load until the slot is freed
	always_ff @(posedge clock) begin
		if (load && !busy)
			out_frame <= az;
	end

endmodule

// File: design/lsp_az_top.sv
`timescale 1ns/1ns

module lsp_az_top (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   in_req,
	input  lsp_az_pkg::lsp_frame_u in_frame,
	output logic                   in_ack,
	output logic                   out_req,
	output lsp_az_pkg::az_frame_t  out_frame,
	input  logic                   out_ack
);
	import lsp_az_pkg::*;

	logic       pol_start;
	logic       f1_done;
	logic       f2_done;
	logic       comb_idle;
	logic       comb_go;
	logic       az_load;
	logic       port_busy;
	lsp_half_t  even_lsp;
	lsp_half_t  odd_lsp;
	pol_array_t f1;
	pol_array_t f2;
	az_frame_t  az;

	lsp_frame_decoder u_decoder (
		.clock     (clock),
		.reset     (reset),
		.in_req    (in_req),
		.in_frame  (in_frame),
		.in_ack    (in_ack),
		.pol_start (pol_start),
		.even_lsp  (even_lsp),
		.odd_lsp   (odd_lsp),
		.f1_done   (f1_done),
		.f2_done   (f2_done),
		.comb_idle (comb_idle),
		.comb_go   (comb_go)
	);

	// f1 from the even LSPs, f2 from the odd ones
	lsp_pol_builder u_f1_builder (
		.clock (clock),
		.reset (reset),
		.start (pol_start),
		.lsp   (even_lsp),
		.done  (f1_done),
		.pol   (f1)
	);

	lsp_pol_builder u_f2_builder (
		.clock (clock),
		.reset (reset),
		.start (pol_start),
		.lsp   (odd_lsp),
		.done  (f2_done),
		.pol   (f2)
	);

	az_combiner u_combiner (
		.clock     (clock),
		.reset     (reset),
		.go        (comb_go),
		.f1        (f1),
		.f2        (f2),
		.idle      (comb_idle),
		.port_busy (port_busy),
		.load      (az_load),
		.az        (az)
	);

	az_result_port u_result (
		.clock     (clock),
		.reset     (reset),
		.load      (az_load),
		.az        (az),
		.busy      (port_busy),
		.out_req   (out_req),
		.out_frame (out_frame),
		.out_ack   (out_ack)
	);

endmodule

// File: tests/lsp_az_ref.svh
`ifndef LSP_AZ_REF_SVH
`define LSP_AZ_REF_SVH

//////////////////////////////////////////////////////////////////////
// G.729 basic operators, worked on 64-bit integers
//////////////////////////////////////////////////////////////////////

localparam longint WORD32_MAX = 64'sh7fff_ffff;
localparam longint WORD32_MIN = -64'sh8000_0000;

function automatic longint clamp32(input longint v);
	if (v > WORD32_MAX)
		return WORD32_MAX;
	if (v < WORD32_MIN)
		return WORD32_MIN;
	return v;
endfunction

function automatic longint clamp16(input longint v);
	if (v > 32767)
		return 32767;
	if (v < -32768)
		return -32768;
	return v;
endfunction

function automatic longint l_add(input longint a, input longint b);
	return clamp32(a + b);
endfunction

function automatic longint l_sub(input longint a, input longint b);
	return clamp32(a - b);
endfunction

function automatic longint l_mult(input longint a, input longint b);
	return clamp32(a * b * 2);
endfunction

function automatic longint mult_q15(input longint a, input longint b);
	return clamp16((a * b) >>> 15);
endfunction

// hi*n*2 plus the Q15 product of the halved low word, doubled
function automatic longint mpy_32_16(input longint hi, input longint lo, input longint n);
	return l_add(l_mult(hi, n), mult_q15(lo, n) * 2);
endfunction

// L_shr_r by 13 and extract_l
function automatic logic [15:0] shift_round(input longint v);
	longint r;
	r = (v >>> 13) + ((v >>> 12) & 1);
	return r[15:0];
endfunction

// Five LSPs to f[0..5] in Q24
function automatic void build_pol(input longint n [5], output longint f [6]);
	longint hi;
	longint lo;
	longint t0;
	f[0] = 64'sd16777216;
	f[1] = l_sub(0, l_mult(n[0], 512));
	for (int i = 2; i <= 5; i++) begin
		f[i] = f[i-2];
		for (int j = i; j >= 2; j--) begin
			hi = f[j-1] >>> 16;
			lo = (f[j-1] & 64'hffff) >>> 1;
			t0 = clamp32(mpy_32_16(hi, lo, n[i-1]) * 2);
			f[j] = l_sub(l_add(f[j], f[j-2]), t0);
		end
		f[1] = l_sub(f[1], l_mult(n[i-1], 512));
	end
endfunction

function automatic az_frame_t lsp_to_az(input lsp_frame_u fr);
	longint ev [5];
	longint od [5];
	longint f1 [6];
	longint f2 [6];
	az_frame_t a;
	for (int k = 0; k < 5; k++) begin
		ev[k] = fr.lsp[2*k];
		od[k] = fr.lsp[2*k+1];
	end
	build_pol(ev, f1);
	build_pol(od, f2);
	for (int i = 5; i >= 1; i--) begin
		f1[i] = l_add(f1[i], f1[i-1]);
		f2[i] = l_sub(f2[i], f2[i-1]);
	end
	a[0] = 16'sd4096;
	for (int i = 1; i <= 5; i++) begin
		a[i]    = shift_round(l_add(f1[i], f2[i]));
		a[11-i] = shift_round(l_sub(f1[i], f2[i]));
	end
	return a;
endfunction

// x^32 + x^22 + x^2 + x + 1, one shift per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: tests/lsp_az_tb.sv
`timescale 1ns/1ns
`include "lsp_az_defines.svh"

module lsp_az_tb;
	import lsp_az_pkg::*;

	`include "lsp_az_ref.svh"

	localparam int NUM_RANDOM  = 20;
	localparam int NUM_STALL   = 10;
	localparam int NUM_FRAMES  = 2 + NUM_RANDOM + NUM_STALL;
	localparam int CYCLE_LIMIT = 200 * NUM_FRAMES + 500;

	logic       clock;
	logic       reset;
	logic       in_req;
	logic       in_ack;
	logic       out_req;
	logic       out_ack;
	lsp_frame_u in_frame;
	az_frame_t  out_frame;

	az_frame_t   expected_q[$];
	string       name_q[$];
	az_frame_t   cur_exp;
	az_frame_t   held_frame;
	string       cur_name;
	logic [31:0] lfsr_state;
	logic        out_req_prev;
	logic        out_ack_prev;
	logic        in_ack_prev;
	logic        in_req_prev;
	int          cycles;
	int          sent;
	int          received;
	int          ack_delay_max;

	lsp_az_top dut0 (
		.clock     (clock),
		.reset     (reset),
		.in_req    (in_req),
		.in_frame  (in_frame),
		.in_ack    (in_ack),
		.out_req   (out_req),
		.out_frame (out_frame),
		.out_ack   (out_ack)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	function automatic lsp_frame_u frame_from_ints(input int v [10]);
		lsp_frame_u fr;
		for (int k = 0; k < `LSP_AZ_ORDER; k++)
			fr.lsp[k] = 16'(v[k]);
		return fr;
	endfunction

	// Descending cosines in -32000..32000
	function automatic lsp_frame_u random_frame();
		int v [10];
		int t;
		for (int k = 0; k < `LSP_AZ_ORDER; k++)
			v[k] = int'((longint'(rand_bits(16)) * 64001) >>> 16) - 32000;
		for (int k = 1; k < `LSP_AZ_ORDER; k++) begin
			for (int m = k; m > 0 && v[m] > v[m-1]; m--) begin
				t      = v[m];
				v[m]   = v[m-1];
				v[m-1] = t;
			end
		end
		return frame_from_ints(v);
	endfunction

	task automatic check_value(input string name, input longint expected, input longint actual);
		if (expected != actual) begin
			$display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
			$display("Verification failed");
			$fatal(1, "Stopping at first error");
		end
	endtask

	task automatic send_frame(input lsp_frame_u fr, input string name);
		expected_q.push_back(lsp_to_az(fr));
		name_q.push_back(name);
		@(posedge clock);
		#1;
		in_frame = fr;
		in_req   = 1'b1;
		do @(negedge clock); while (!in_ack);
		@(posedge clock);
		#1;
		in_req = 1'b0;
		do @(negedge clock); while (in_ack);
		sent++;
	endtask

	task automatic wait_outputs();
		do @(negedge clock); while (received != sent);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sink with optional random ack delay
	//////////////////////////////////////////////////////////////////////

	initial begin
		int delay;
		forever begin
			do @(negedge clock); while (!out_req);
			@(posedge clock);
			#1;
			delay = (ack_delay_max > 0) ? rand_bits(6) % (ack_delay_max + 1) : 0;
			repeat (delay) begin
				@(posedge clock);
				#1;
			end
			out_ack = 1'b1;
			do @(negedge clock); while (out_req);
			@(posedge clock);
			#1;
			out_ack = 1'b0;
		end
	end

	// Comparison and protocol monitor
	always @(negedge clock) begin
		if (!reset) begin
			if (out_req && !out_req_prev) begin
				if (expected_q.size() == 0) begin
					$display("An output frame arrived with no input frame outstanding");
					$display("Verification failed");
					$fatal(1, "Unexpected output frame");
				end else begin
					cur_exp  = expected_q.pop_front();
					cur_name = name_q.pop_front();
					for (int k = 0; k <= `LSP_AZ_ORDER; k++)
						check_value($sformatf("%s a[%0d]", cur_name, k), cur_exp[k], out_frame[k]);
					held_frame = out_frame;
					received++;
				end
			end else if (out_req) begin
				for (int k = 0; k <= `LSP_AZ_ORDER; k++)
					check_value($sformatf("%s hold a[%0d]", cur_name, k), held_frame[k],
						out_frame[k]);
			end
			if (out_req_prev && !out_req)
				check_value("out_req release after out_ack", 1, out_ack_prev);
			if (in_ack && !in_ack_prev)
				check_value("in_ack rise with in_req", 1, in_req);
			if (in_ack_prev && !in_ack)
				check_value("in_ack release after in_req", 0, in_req_prev);
		end
		out_req_prev = out_req;
		out_ack_prev = out_ack;
		in_ack_prev  = in_ack;
		in_req_prev  = in_req;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: output frames did not arrive within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$fatal(1, "Simulation stopped on timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int         g729_init [10];
		int         spaced [10];
		lsp_frame_u fr;
		reset         = 1'b1;
		in_req        = 1'b0;
		in_frame      = '0;
		out_ack       = 1'b0;
		lfsr_state    = 32'he86b_9669;
		out_req_prev  = 1'b0;
		out_ack_prev  = 1'b0;
		in_ack_prev   = 1'b0;
		in_req_prev   = 1'b0;
		cycles        = 0;
		sent          = 0;
		received      = 0;
		ack_delay_max = 0;
		g729_init = '{30000, 26000, 21000, 15000, 8000, 0, -8000, -15000, -21000, -26000};
		spaced    = '{32000, 24500, 16500, 8200, 300, -7800, -16100, -24300, -30900, -32000};

		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (3) begin
			@(negedge clock);
			check_value("reset in_ack", 0, in_ack);
			check_value("reset out_req", 0, out_req);
		end

		// Standard initial frame
		fr = frame_from_ints(g729_init);
		send_frame(fr, "initial frame");
		wait_outputs();

		for (int n = 0; n < NUM_RANDOM; n++)
			send_frame(random_frame(), $sformatf("random frame %0d", n));
		wait_outputs();

		ack_delay_max = 60;
		for (int n = 0; n < NUM_STALL; n++)
			send_frame(random_frame(), $sformatf("stalled frame %0d", n));
		wait_outputs();

		ack_delay_max = 0;
		send_frame(frame_from_ints(spaced), "spaced frame");
		wait_outputs();

		// Quiet window for any stray output frame
		repeat (4) @(negedge clock);

		$display("Verification passed");
		$finish;
	end

endmodule

// File: build.f
+incdir+design
+incdir+tests
design/lsp_az_pkg.sv
design/lsp_frame_decoder.sv
design/lsp_pol_builder.sv
design/az_combiner.sv
design/az_result_port.sv
design/lsp_az_top.sv
tests/lsp_az_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the LSP to LPC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module lsp_az_tb -f build.f -o sim_lsp_az

# The simulator exits non-zero on failure, so the log decides
./obj_dir/sim_lsp_az > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi

if ! grep -q "Verification passed" sim.log; then
	echo "Simulation ended without a pass message"
	exit 1
fi

exit 0
